//--- hdl/noc_topo_pkg.sv
// mesh topology definitions
`default_nettype none

package noc_topo_pkg;

  //////////////////////////////////////////////////
  // coordinates
  //////////////////////////////////////////////////

  // bits per mesh coordinate
  localparam int unsigned coord_width = 4;

  // tile position on the mesh
  // north is y minus one, east is x plus one
  typedef struct packed {
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;
  } xy_t;

  //////////////////////////////////////////////////
  // ports and directions
  //////////////////////////////////////////////////

  // four mesh links plus the local tile
  localparam int unsigned num_ports = 5;

  // port index, also the bit position in direction_t
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } noc_port_t;

  // one-hot direction, bit i selects port i
  typedef logic [num_ports-1:0] direction_t;

endpackage

`default_nettype wire

//--- hdl/noc_flit_pkg.sv
// flit format definitions
`default_nettype none

package noc_flit_pkg;

  import noc_topo_pkg::*;

  // payload width without the preamble
  localparam int unsigned data_width = 32;

  // head and tail markers, both set on a single-flit packet
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  // whatever the header leaves over in the word
  localparam int unsigned reserved_width =
    data_width - 2 * $bits(xy_t) - $bits(direction_t);

  //////////////////////////////////////////////////
  // head flit layout
  //////////////////////////////////////////////////

  // routing sits in the low bits so the look-ahead rewrite is a plain splice
  typedef struct packed {
    preamble_t                 preamble;
    xy_t                       source;
    xy_t                       destination;
    logic [reserved_width-1:0] reserved;
    direction_t                routing;
  } header_t;

  // one link word, read as a header or as raw payload
  typedef union packed {
    header_t               header;
    logic [data_width+1:0] raw;
  } flit_t;

  // forward signals of one link
  typedef struct packed {
    flit_t flit;
    logic  is_void;
  } link_t;

endpackage

`default_nettype wire

//--- hdl/router_input_fifo.sv
// router input queue
`timescale 1ns/1ps
`default_nettype none

module router_input_fifo
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;
#(
  parameter int unsigned DataWidth = data_width,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  link_t                link_i,
  output logic                 stop_o,
  input  logic [num_ports-1:0] read_i,
  output flit_t                head_o,
  output logic                 valid_o,
  output direction_t           request_o
);

  localparam int unsigned PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  // storage for queued flits
  logic [DataWidth+1:0]  mem_q [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  empty;
  logic                  full;
  logic                  rd;
  logic                  push;
  logic                  pop;
  // routing of the worm currently leaving this queue
  direction_t            saved_request_q;

  assign empty  = (count_q == '0);
  assign full   = (count_q == CountWidth'(FifoDepth));
  // stop the upstream sender while there is no room
  assign stop_o = full;

  // at most one output reads us, so a plain or is enough
  assign rd = |read_i;

  //////////////////////////////////////////////////
  // head selection with bypass
  //////////////////////////////////////////////////

  // empty queue shows the incoming flit directly
  assign head_o  = empty ? link_i.flit : flit_t'(mem_q[rd_ptr_q]);
  assign valid_o = empty ? ~link_i.is_void : 1'b1;

  // a bypassed flit read in the same cycle is never stored
  assign pop  = rd & ~empty;
  assign push = ~link_i.is_void & ~full & ~(empty & rd);

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= link_i.flit;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // worm routing request
  //////////////////////////////////////////////////

  // capture on the head read and drop once the tail has gone
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request_q <= '0;
    end else if (rd) begin
      if (head_o.header.preamble.tail) begin
        saved_request_q <= '0;
      end else if (head_o.header.preamble.head) begin
        saved_request_q <= head_o.header.routing;
      end
    end
  end

  // a waiting head asks with its own field and payload flits reuse the saved one
  assign request_o = (valid_o && head_o.header.preamble.head) ? head_o.header.routing
                                                               : saved_request_q;

  // outputs only consume flits that are actually there
  a_read_needs_valid: assert property (@(posedge clk) disable iff (rst)
    rd |-> valid_o)
    else $error("router_input_fifo: read of an empty head");

endmodule

`default_nettype wire

//--- hdl/router_arbiter.sv
// worm-locking round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module router_arbiter
  import noc_topo_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_ports-1:0] request_i,
  input  logic                 head_sent_i,
  input  logic                 tail_sent_i,
  output logic [num_ports-1:0] grant_o,
  output logic                 grant_valid_o
);

  logic                 locked_q;
  logic [num_ports-1:0] grant_q;
  logic [num_ports-1:0] rr_grant;
  // last input that started a worm
  noc_port_t            last_q;
  noc_port_t            winner;

  //////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////

  // search starts right after the previous winner
  always_comb begin
    int unsigned idx;
    logic        found;
    rr_grant = '0;
    winner   = last_q;
    found    = 1'b0;
    idx      = 0;
    for (int unsigned k = 1; k <= num_ports; k++) begin
      idx = (int'(last_q) + k) % num_ports;
      if (!found && request_i[idx]) begin
        rr_grant[idx] = 1'b1;
        winner        = noc_port_t'(idx);
        found         = 1'b1;
      end
    end
  end

  // held grant wins while a worm is in flight
  assign grant_o       = locked_q ? grant_q : rr_grant;
  assign grant_valid_o = |grant_o;

  //////////////////////////////////////////////////
  // lock from head to tail
  //////////////////////////////////////////////////

  // tail wins over head so a single-flit packet never locks
  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q <= 1'b0;
      last_q   <= port_local;
    end else begin
      if (tail_sent_i) begin
        locked_q <= 1'b0;
      end else if (head_sent_i) begin
        locked_q <= 1'b1;
      end
      // priority moves on with every new worm
      if (head_sent_i && !locked_q) begin
        last_q <= winner;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (head_sent_i && !locked_q) begin
      grant_q <= rr_grant;
    end
  end

  // at most one input granted and never one without a request
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant_o) && ((grant_o & ~request_i) == '0))
    else $error("router_arbiter: grant is not one-hot or has no request");

endmodule

`default_nettype wire

//--- hdl/lookahead_route.sv
// look-ahead XY routing
`timescale 1ns/1ps
`default_nettype none

module lookahead_route
  import noc_topo_pkg::*;
(
  input  xy_t        position_i,
  input  noc_port_t  out_port_i,
  input  xy_t        destination_i,
  output direction_t next_routing_o
);

  xy_t        neighbor;
  direction_t xy_route;
  // port through which the flit enters the neighbor
  direction_t arrival;

  // coordinate of the router behind this output
  always_comb begin
    neighbor = position_i;
    arrival  = '0;
    case (out_port_i)
      port_north: begin
        neighbor.y          = position_i.y - 1'b1;
        arrival[port_south] = 1'b1;
      end
      port_south: begin
        neighbor.y          = position_i.y + 1'b1;
        arrival[port_north] = 1'b1;
      end
      port_west: begin
        neighbor.x         = position_i.x - 1'b1;
        arrival[port_east] = 1'b1;
      end
      port_east: begin
        neighbor.x         = position_i.x + 1'b1;
        arrival[port_west] = 1'b1;
      end
      // local output, the flit leaves the mesh here
      default: begin
        neighbor = position_i;
      end
    endcase
  end

  // x first, then y, then the tile
  always_comb begin
    xy_route = '0;
    if (destination_i.x > neighbor.x) begin
      xy_route[port_east] = 1'b1;
    end else if (destination_i.x < neighbor.x) begin
      xy_route[port_west] = 1'b1;
    end else if (destination_i.y > neighbor.y) begin
      xy_route[port_south] = 1'b1;
    end else if (destination_i.y < neighbor.y) begin
      xy_route[port_north] = 1'b1;
    end else begin
      xy_route[port_local] = 1'b1;
    end
  end

  // never send a worm back where it came from
  assign next_routing_o = xy_route & ~arrival;

endmodule

`default_nettype wire

//--- hdl/router_output_port.sv
// router output port
`timescale 1ns/1ps
`default_nettype none

module router_output_port
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;
#(
  parameter int unsigned DataWidth  = data_width,
  parameter noc_port_t   port_index = port_local
) (
  input  logic                        clk,
  input  logic                        rst,
  input  xy_t                         position_i,
  input  flit_t [num_ports-1:0]       heads_i,
  input  logic  [num_ports-1:0]       valids_i,
  input  logic  [num_ports-1:0]       requests_i,
  input  logic                        stop_i,
  output logic  [num_ports-1:0]       read_o,
  output link_t                       link_o
);

  // fsm encoding
  localparam logic [1:0] st_reserve = 2'd0;
  localparam logic [1:0] st_head    = 2'd1;
  localparam logic [1:0] st_payload = 2'd2;

  logic [1:0]           state_q;
  logic [1:0]           state_d;
  logic [num_ports-1:0] grant;
  logic                 grant_valid;
  flit_t                selected;
  logic                 selected_valid;
  logic                 forwarding;
  logic                 head_sent;
  logic                 tail_sent;
  direction_t           next_routing;
  flit_t                out_flit;
  // output register
  flit_t                flit_q;
  logic                 void_q;

  router_arbiter arbiter_inst (
    .clk           (clk),
    .rst           (rst),
    .request_i     (requests_i),
    .head_sent_i   (head_sent),
    .tail_sent_i   (tail_sent),
    .grant_o       (grant),
    .grant_valid_o (grant_valid)
  );

  //////////////////////////////////////////////////
  // crossbar
  //////////////////////////////////////////////////

  // grant is one-hot, so at most one input is picked
  always_comb begin
    selected       = '0;
    selected_valid = 1'b0;
    for (int i = 0; i < num_ports; i++) begin
      if (grant[i]) begin
        selected       = heads_i[i];
        selected_valid = valids_i[i];
      end
    end
  end

  // a flit moves only once the port is reserved and downstream has room
  assign forwarding = (state_q != st_reserve) & selected_valid & ~stop_i;
  assign head_sent  = forwarding & selected.header.preamble.head;
  assign tail_sent  = forwarding & selected.header.preamble.tail;
  assign read_o     = {num_ports{forwarding}} & grant;

  //////////////////////////////////////////////////
  // look-ahead rewrite
  //////////////////////////////////////////////////

  lookahead_route lookahead_inst (
    .position_i     (position_i),
    .out_port_i     (port_index),
    .destination_i  (selected.header.destination),
    .next_routing_o (next_routing)
  );

  // only the head flit carries a routing field
  assign out_flit = (state_q == st_head)
                  ? flit_t'({selected.raw[DataWidth+1:num_ports], next_routing})
                  : selected;

  //////////////////////////////////////////////////
  // reserve / head / payload fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_reserve: begin
        if (grant_valid && !stop_i) begin
          state_d = st_head;
        end
      end
      st_head: begin
        // single-flit packets go straight back to reserve
        if (forwarding) begin
          state_d = selected.header.preamble.tail ? st_reserve : st_payload;
        end
      end
      st_payload: begin
        if (tail_sent) begin
          state_d = st_reserve;
        end
      end
      default: begin
        state_d = st_reserve;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_reserve;
    end else begin
      state_q <= state_d;
    end
  end

  // void follows the crossbar, frozen while downstream stalls
  always_ff @(posedge clk) begin
    if (rst) begin
      void_q <= 1'b1;
    end else if (!stop_i) begin
      void_q <= ~forwarding;
    end
  end

  always_ff @(posedge clk) begin
    if (forwarding) begin
      flit_q <= out_flit;
    end
  end

  assign link_o = '{flit: flit_q, is_void: void_q};

  // the queue request logic must never hand a payload flit to a new worm
  a_head_in_head_state: assert property (@(posedge clk) disable iff (rst)
    (state_q == st_head && selected_valid) |-> selected.header.preamble.head)
    else $error("router_output_port: payload flit at worm start");

endmodule

`default_nettype wire

//--- hdl/noc_router.sv
// mesh router top level
`timescale 1ns/1ps
`default_nettype none

module noc_router
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;
#(
  parameter int unsigned DataWidth = data_width,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  xy_t                   position_i,
  input  link_t [num_ports-1:0] link_i,
  output logic  [num_ports-1:0] stop_o,
  output link_t [num_ports-1:0] link_o,
  input  logic  [num_ports-1:0] stop_i
);

  // per input queue
  flit_t      [num_ports-1:0] fifo_head;
  logic       [num_ports-1:0] fifo_valid;
  direction_t [num_ports-1:0] fifo_request;
  // indexed [input][output]
  logic [num_ports-1:0][num_ports-1:0] fifo_read;
  // indexed [output][input]
  logic [num_ports-1:0][num_ports-1:0] out_request;
  logic [num_ports-1:0][num_ports-1:0] out_read;

  //////////////////////////////////////////////////
  // input queues
  //////////////////////////////////////////////////

  for (genvar g_in = 0; g_in < num_ports; g_in++) begin : g_input
    router_input_fifo #(
      .DataWidth (DataWidth),
      .FifoDepth (FifoDepth)
    ) input_fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .link_i    (link_i[g_in]),
      .stop_o    (stop_o[g_in]),
      .read_i    (fifo_read[g_in]),
      .head_o    (fifo_head[g_in]),
      .valid_o   (fifo_valid[g_in]),
      .request_o (fifo_request[g_in])
    );
  end

  //////////////////////////////////////////////////
  // output ports
  //////////////////////////////////////////////////

  for (genvar g_out = 0; g_out < num_ports; g_out++) begin : g_output
    router_output_port #(
      .DataWidth  (DataWidth),
      .port_index (noc_port_t'(g_out))
    ) output_port_inst (
      .clk        (clk),
      .rst        (rst),
      .position_i (position_i),
      .heads_i    (fifo_head),
      .valids_i   (fifo_valid),
      .requests_i (out_request[g_out]),
      .stop_i     (stop_i[g_out]),
      .read_o     (out_read[g_out]),
      .link_o     (link_o[g_out])
    );
  end

  // requests go from input rows to output rows, reads come back the other way
  for (genvar g_i = 0; g_i < num_ports; g_i++) begin : g_transpose_row
    for (genvar g_j = 0; g_j < num_ports; g_j++) begin : g_transpose_col
      assign out_request[g_j][g_i] = fifo_request[g_i][g_j];
      assign fifo_read[g_i][g_j]   = out_read[g_j][g_i];
    end
  end

endmodule

`default_nettype wire

//--- bench/noc_router_model.svh
// router reference model
`ifndef NOC_ROUTER_MODEL_SVH
`define NOC_ROUTER_MODEL_SVH

// plain XY choice from one tile toward a destination
function automatic direction_t model_xy_route(input xy_t here, input xy_t dest);
  direction_t d;
  d = '0;
  if (dest.x > here.x) begin
    d[port_east] = 1'b1;
  end else if (dest.x < here.x) begin
    d[port_west] = 1'b1;
  end else if (dest.y > here.y) begin
    d[port_south] = 1'b1;
  end else if (dest.y < here.y) begin
    d[port_north] = 1'b1;
  end else begin
    d[port_local] = 1'b1;
  end
  return d;
endfunction

// one-hot field back to a port index
function automatic noc_port_t route_port(input direction_t d);
  noc_port_t r;
  r = port_local;
  for (int i = 0; i < num_ports; i++) begin
    if (d[i]) begin
      r = noc_port_t'(i);
    end
  end
  return r;
endfunction

// field the neighbor behind out_port must see in the head flit
function automatic direction_t model_next_routing(input xy_t here, input noc_port_t out_port,
                                                  input xy_t dest);
  xy_t        nb;
  direction_t back;
  nb   = here;
  back = '0;
  case (out_port)
    port_north: begin
      nb.y             = here.y - 4'd1;
      back[port_south] = 1'b1;
    end
    port_south: begin
      nb.y             = here.y + 4'd1;
      back[port_north] = 1'b1;
    end
    port_west: begin
      nb.x            = here.x - 4'd1;
      back[port_east] = 1'b1;
    end
    port_east: begin
      nb.x            = here.x + 4'd1;
      back[port_west] = 1'b1;
    end
    default: begin
      nb = here;
    end
  endcase
  // a worm never turns back into the link it came from
  return model_xy_route(nb, dest) & ~back;
endfunction

`endif

//--- bench/noc_router_tb.sv
// mesh router testbench
`timescale 1ns/1ps
`default_nettype none

module noc_router_tb
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;
;

  localparam xy_t position = '{x: 4'd2, y: 4'd2};

  logic                  clk;
  logic                  rst;
  link_t [num_ports-1:0] link_in;
  logic  [num_ports-1:0] stop_out;
  link_t [num_ports-1:0] link_out;
  logic  [num_ports-1:0] stop_in;

  // per-port drive values written by one process per input
  link_t drive_link [num_ports];
  // flits still to send on each input
  flit_t send_q [num_ports][$];
  // expected flits indexed by output * num_ports + source
  flit_t exp_q [num_ports*num_ports][$];
  // worm tracking per output
  logic  in_worm [num_ports];
  int    cur_src [num_ports];
  int    total_flits;
  int    pkt_count;
  int    cycles;
  logic  random_stop;
  string cur_test;

  `include "noc_router_model.svh"

  noc_router #(
    .DataWidth (data_width),
    .FifoDepth (4)
  ) noc_router_inst (
    .clk        (clk),
    .rst        (rst),
    .position_i (position),
    .link_i     (link_in),
    .stop_o     (stop_out),
    .link_o     (link_out),
    .stop_i     (stop_in)
  );

  for (genvar g = 0; g < num_ports; g++) begin : g_drive
    assign link_in[g] = drive_link[g];
  end

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      $display("** Error %s: flit expected %h actual %h", name, exp.raw, act.raw);
      abort_run();
    end
  endtask

  task automatic check_port(input string name, input noc_port_t exp, input noc_port_t act);
    if (act !== exp) begin
      $display("** Error %s: port expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %b actual %b", name, what, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////

  // builds one packet and its expected image on the XY output
  task automatic make_packet(input noc_port_t src, input xy_t dest, input int len);
    flit_t     f;
    flit_t     e;
    noc_port_t out;
    int        idx;
    out = route_port(model_xy_route(position, dest));
    idx = int'(out) * num_ports + int'(src);
    f = '0;
    f.header.preamble.head = 1'b1;
    f.header.preamble.tail = (len == 1);
    f.header.source        = '{x: 4'(src), y: 4'hf};
    f.header.destination   = dest;
    // source port in the low reserved bits tells the monitor who sent it
    f.header.reserved      = {8'(pkt_count), 3'(src)};
    f.header.routing       = model_xy_route(position, dest);
    e = f;
    e.header.routing = model_next_routing(position, out, dest);
    send_q[src].push_back(f);
    exp_q[idx].push_back(e);
    for (int k = 1; k < len; k++) begin
      f.raw = {1'b0, (k == len - 1), $urandom()};
      send_q[src].push_back(f);
      exp_q[idx].push_back(f);
    end
    total_flits += len;
    pkt_count++;
  endtask

  // random destination that is consistent with the arrival port
  task automatic random_packet(input noc_port_t src);
    xy_t       dest;
    noc_port_t out;
    do begin
      dest = '{x: 4'($urandom_range(4, 0)), y: 4'($urandom_range(4, 0))};
      out  = route_port(model_xy_route(position, dest));
    end while (out == src && src != port_local);
    make_packet(src, dest, int'($urandom_range(4, 1)));
  endtask

  // sends one input's queue and holds each flit while stop_o is high
  task automatic send_all(input int p);
    flit_t f;
    logic  accepted;
    @(negedge clk);
    while (send_q[p].size() > 0) begin
      f = send_q[p].pop_front();
      drive_link[p] = '{flit: f, is_void: 1'b0};
      accepted = 1'b0;
      while (!accepted) begin
        // stop_o only changes at a rising edge
        accepted = !stop_out[p];
        @(negedge clk);
      end
    end
    drive_link[p].is_void = 1'b1;
  endtask

  task automatic run_all();
    fork
      send_all(0);
      send_all(1);
      send_all(2);
      send_all(3);
      send_all(4);
    join
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < num_ports * num_ports; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    while (pending() != 0) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////

  task automatic take_flit(input int p, input flit_t f);
    int    src;
    int    idx;
    flit_t exp;
    if (f.header.preamble.head) begin
      if (in_worm[p]) begin
        $display("new head on output %0d inside a running worm", p);
        abort_run();
      end
      cur_src[p] = int'(f.header.reserved[2:0]);
      check_port(cur_test, route_port(model_xy_route(position, f.header.destination)),
                 noc_port_t'(p));
      in_worm[p] = !f.header.preamble.tail;
    end else begin
      if (!in_worm[p]) begin
        $display("payload flit on output %0d without a head", p);
        abort_run();
      end
      if (f.header.preamble.tail) begin
        in_worm[p] = 1'b0;
      end
    end
    src = cur_src[p];
    idx = p * num_ports + src;
    if (exp_q[idx].size() == 0) begin
      $display("unexpected flit on output %0d from input %0d", p, src);
      abort_run();
    end
    exp = exp_q[idx].pop_front();
    check_flit(cur_test, exp, f);
  endtask

  // a flit leaves where void and the facing stop are both low
  always @(posedge clk) begin
    if (!rst) begin
      for (int p = 0; p < num_ports; p++) begin
        if (!link_out[p].is_void && !stop_in[p]) begin
          take_flit(p, link_out[p].flit);
        end
      end
    end
  end

  // run limit grows with the traffic
  always @(posedge clk) begin
    cycles++;
    if (cycles > 20 * total_flits + 200) begin
      $display("timeout after %0d cycles with %0d flits pending", cycles, pending());
      abort_run();
    end
  end

  ////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////

  initial begin
    int n;
    void'($urandom(32'h15ed_249c));
    rst = 1'b1;
    stop_in = '0;
    random_stop = 1'b0;
    total_flits = 0;
    pkt_count = 0;
    cycles = 0;
    cur_test = "reset";
    for (int p = 0; p < num_ports; p++) begin
      drive_link[p] = '{flit: '0, is_void: 1'b1};
      in_worm[p] = 1'b0;
      cur_src[p] = 0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle outputs after reset
    for (int p = 0; p < num_ports; p++) begin
      check_bit(cur_test, $sformatf("void on port %0d", p), 1'b1, link_out[p].is_void);
      check_bit(cur_test, $sformatf("stop on port %0d", p), 1'b0, stop_out[p]);
    end

    // single flits from the local tile in every direction
    cur_test = "single_flit";
    make_packet(port_local, '{x: 4'd2, y: 4'd0}, 1);
    make_packet(port_local, '{x: 4'd2, y: 4'd4}, 1);
    make_packet(port_local, '{x: 4'd0, y: 4'd2}, 1);
    make_packet(port_local, '{x: 4'd4, y: 4'd2}, 1);
    make_packet(port_local, '{x: 4'd2, y: 4'd2}, 1);
    make_packet(port_local, '{x: 4'd4, y: 4'd4}, 1);
    make_packet(port_local, '{x: 4'd0, y: 4'd0}, 1);
    run_all();
    wait_drain();

    // one long worm northward
    cur_test = "worm";
    make_packet(port_local, '{x: 4'd2, y: 4'd0}, 6);
    run_all();
    wait_drain();

    // worms from three inputs competing for east
    cur_test = "contention";
    make_packet(port_north, '{x: 4'd4, y: 4'd1}, 4);
    make_packet(port_west, '{x: 4'd3, y: 4'd2}, 4);
    make_packet(port_local, '{x: 4'd4, y: 4'd3}, 4);
    make_packet(port_west, '{x: 4'd4, y: 4'd2}, 3);
    run_all();
    wait_drain();

    // held east output must not stall north to south traffic
    cur_test = "backpressure";
    @(negedge clk);
    stop_in[port_east] = 1'b1;
    for (int k = 0; k < 8; k++) begin
      make_packet(port_local, '{x: 4'd4, y: 4'd2}, 1);
    end
    for (int k = 0; k < 4; k++) begin
      make_packet(port_north, '{x: 4'd2, y: 4'd4}, 2);
    end
    fork
      send_all(port_local);
      send_all(port_north);
    join_none
    n = 0;
    while (!stop_out[port_local]) begin
      @(negedge clk);
      n++;
      if (n > 100) begin
        $display("local stop_o never rose while east was held");
        abort_run();
      end
    end
    n = 0;
    while (exp_q[int'(port_south) * num_ports + int'(port_north)].size() != 0) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        $display("south traffic stalled behind the held east output");
        abort_run();
      end
    end
    repeat (30) @(negedge clk);
    stop_in[port_east] = 1'b0;
    wait fork;
    wait_drain();

    // random traffic with random stops
    cur_test = "random";
    for (int s = 0; s < num_ports; s++) begin
      for (int k = 0; k < 12; k++) begin
        random_packet(noc_port_t'(s));
      end
    end
    random_stop = 1'b1;
    fork
      begin
        run_all();
        random_stop = 1'b0;
      end
      begin
        while (random_stop) begin
          @(negedge clk);
          // roughly one in four cycles stalled per output
          for (int p = 0; p < num_ports; p++) begin
            stop_in[p] = ($urandom_range(3, 0) == 0);
          end
        end
      end
    join
    @(negedge clk);
    stop_in = '0;
    wait_drain();
    repeat (5) @(posedge clk);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+bench
hdl/noc_topo_pkg.sv
hdl/noc_flit_pkg.sv
hdl/router_input_fifo.sv
hdl/router_arbiter.sv
hdl/lookahead_route.sv
hdl/router_output_port.sv
hdl/noc_router.sv
bench/noc_router_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= noc_router_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
